// ==== mm_map_pkg.sv ====
// memory map of the board bus; addresses and data are fixed at 32 bits and window tags follow the reference layout.
package mm_map_pkg;

    localparam int addr_w          = 32;  // bus address width in bits.
    localparam int data_w          = 32;  // bus data width in bits.
    localparam int ram_window_bits = 24;  // the sram window covers 16 MB.
    localparam int io_window_bits  = 20;  // every other window covers 1 MB.

    // module numbers exactly as the reference decoder hands them out.
    typedef enum logic [7:0] {
        mod_rom       = 8'd0,   // bootloader rom, also the default for unmatched addresses.
        mod_ram       = 8'd1,   // word sram.
        mod_uart      = 8'd2,
        mod_switches  = 8'd3,
        mod_leds      = 8'd4,
        mod_gpio      = 8'd5,
        mod_vga       = 8'd6,
        mod_plpid     = 8'd7,
        mod_timer     = 8'd8,
        mod_sseg      = 8'd9,   // numbered below the interrupt controller in the reference.
        mod_interrupt = 8'd10
    } mm_module_e;

    // window bases, compared only on the bits above each window.
    localparam logic [addr_w-1:0] rom_base       = 32'h0000_0000;
    localparam logic [addr_w-1:0] ram_base       = 32'h1000_0000;
    localparam logic [addr_w-1:0] uart_base      = 32'hf000_0000;
    localparam logic [addr_w-1:0] switches_base  = 32'hf010_0000;
    localparam logic [addr_w-1:0] leds_base      = 32'hf020_0000;
    localparam logic [addr_w-1:0] gpio_base      = 32'hf030_0000;
    localparam logic [addr_w-1:0] vga_base       = 32'hf040_0000;
    localparam logic [addr_w-1:0] plpid_base     = 32'hf050_0000;
    localparam logic [addr_w-1:0] timer_base     = 32'hf060_0000;
    localparam logic [addr_w-1:0] interrupt_base = 32'hf070_0000;
    localparam logic [addr_w-1:0] sseg_base      = 32'hf0a0_0000;

endpackage

// ==== bus_pkg.sv ====
// bus transaction types; one request is in flight at a time and there is no handshake beyond strobes.
package bus_pkg;

    // operation carried by a registered request.
    typedef enum logic [1:0] {
        op_idle  = 2'd0,  // no request this cycle.
        op_read  = 2'd1,
        op_write = 2'd2
    } bus_op_e;

    // one request as registered from the master strobes.
    typedef struct packed {
        bus_op_e                         op;
        logic [mm_map_pkg::addr_w-1:0]   addr;   // byte address as issued.
        logic [mm_map_pkg::data_w-1:0]   wdata;  // only meaningful with op_write.
    } bus_req_t;

    // one device's read answer.
    typedef struct packed {
        logic                            valid;  // high for one cycle per served read.
        logic [mm_map_pkg::data_w-1:0]   rdata;
    } dev_rsp_t;

    // what the master sees at the end of a request.
    typedef struct packed {
        logic                            done;   // one pulse per request.
        logic                            error;  // qualified by done.
        logic [mm_map_pkg::data_w-1:0]   rdata;  // valid on error-free reads.
    } bus_rsp_t;

endpackage

// ==== bus_request_reg.sv ====
// input stage; rd and wr are one-cycle strobes that must never be high together and must be at least three cycles apart.
`timescale 1ns/1ps

module bus_request_reg (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          rd,        // read strobe from the master.
    input  logic                          wr,        // write strobe from the master.
    input  logic [mm_map_pkg::addr_w-1:0] addr,
    input  logic [mm_map_pkg::data_w-1:0] wdata,
    output bus_pkg::bus_req_t             req,
    output logic                          misalign   // level that travels with req.
);

    always_ff @(posedge clk) begin
        if (reset) begin
            req.op   <= bus_pkg::op_idle;
            misalign <= 1'b0;
        end else begin
            if (wr) begin
                req.op <= bus_pkg::op_write;  // a write strobe wins the encoding.
            end else if (rd) begin
                req.op <= bus_pkg::op_read;
            end else begin
                req.op <= bus_pkg::op_idle;  // the request lasts exactly one cycle.
            end
            misalign <= (rd || wr) && (addr[1:0] != 2'b00);  // only word accesses are legal.
        end
        if (rd || wr) begin
            req.addr  <= addr;   // address and data hold until the next strobe.
            req.wdata <= wdata;
        end
    end

    // the op encoding cannot express a combined read and write.
    assert property (@(posedge clk) disable iff (reset) !(rd && wr))
        else $error("rd and wr strobed in the same cycle.");

endmodule

// ==== mm.sv ====
// address decoder; purely combinational and matches the reference priority, so unmatched addresses land on the rom.
`timescale 1ns/1ps

module mm (
    input  logic [mm_map_pkg::addr_w-1:0] addr,      // byte address of the current request.
    output mm_map_pkg::mm_module_e        mod,       // module number of the window hit.
    output logic [mm_map_pkg::addr_w-1:0] eff_addr   // offset inside that window.
);

    // true when a falls in the 1 MB window that starts at base.
    function automatic logic io_hit(input logic [mm_map_pkg::addr_w-1:0] a,
                                    input logic [mm_map_pkg::addr_w-1:0] base);
        return a[mm_map_pkg::addr_w-1:mm_map_pkg::io_window_bits] ==
               base[mm_map_pkg::addr_w-1:mm_map_pkg::io_window_bits];
    endfunction

    logic ram_hit;  // the sram window is the only 16 MB one.

    assign ram_hit = addr[mm_map_pkg::addr_w-1:mm_map_pkg::ram_window_bits] ==
                     mm_map_pkg::ram_base[mm_map_pkg::addr_w-1:mm_map_pkg::ram_window_bits];

    // first match wins, in the same order as the reference.
    assign mod = io_hit(addr, mm_map_pkg::rom_base)       ? mm_map_pkg::mod_rom :
                 ram_hit                                  ? mm_map_pkg::mod_ram :
                 io_hit(addr, mm_map_pkg::uart_base)      ? mm_map_pkg::mod_uart :
                 io_hit(addr, mm_map_pkg::switches_base)  ? mm_map_pkg::mod_switches :
                 io_hit(addr, mm_map_pkg::leds_base)      ? mm_map_pkg::mod_leds :
                 io_hit(addr, mm_map_pkg::gpio_base)      ? mm_map_pkg::mod_gpio :
                 io_hit(addr, mm_map_pkg::vga_base)       ? mm_map_pkg::mod_vga :
                 io_hit(addr, mm_map_pkg::plpid_base)     ? mm_map_pkg::mod_plpid :
                 io_hit(addr, mm_map_pkg::timer_base)     ? mm_map_pkg::mod_timer :
                 io_hit(addr, mm_map_pkg::interrupt_base) ? mm_map_pkg::mod_interrupt :
                 io_hit(addr, mm_map_pkg::sseg_base)      ? mm_map_pkg::mod_sseg :
                 mm_map_pkg::mod_rom;

    always_comb begin
        eff_addr = '0;  // upper bits are always stripped.
        if (mod == mm_map_pkg::mod_ram) begin
            eff_addr[mm_map_pkg::ram_window_bits-1:0] = addr[mm_map_pkg::ram_window_bits-1:0];
        end else begin
            eff_addr[mm_map_pkg::io_window_bits-1:0] = addr[mm_map_pkg::io_window_bits-1:0];
        end
    end

endmodule

// ==== mod_sram.sv ====
// word sram; sram_words must be a power of two between 2 and 4M, and higher word indices wrap onto the array.
`timescale 1ns/1ps

module mod_sram #(
    parameter int sram_words = 1024
) (
    input  logic                          clk,
    input  logic                          reset,
    input  bus_pkg::bus_req_t             req,
    input  logic                          misalign,
    input  mm_map_pkg::mm_module_e        mod,
    input  logic [mm_map_pkg::addr_w-1:0] eff_addr,  // byte offset inside the sram window.
    output bus_pkg::dev_rsp_t             rsp
);

    localparam int idx_w = $clog2(sram_words);  // bits of the word index.

    logic [mm_map_pkg::data_w-1:0] mem [sram_words];
    logic [idx_w-1:0]              idx;
    logic                          sel;     // aligned access to the sram window.
    logic                          rd_sel;

    assign idx    = eff_addr[idx_w+1:2];  // dropping upper bits gives the wrap.
    assign sel    = (mod == mm_map_pkg::mod_ram) && !misalign;
    assign rd_sel = sel && (req.op == bus_pkg::op_read);

    always_ff @(posedge clk) begin
        if (sel && (req.op == bus_pkg::op_write)) begin
            mem[idx] <= req.wdata;  // lands at edge 2 of the request.
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rsp.valid <= 1'b0;
        end else begin
            rsp.valid <= rd_sel;  // one-cycle pulse.
        end
        if (rd_sel) begin
            rsp.rdata <= mem[idx];  // registered read.
        end
    end

    // requests are kept apart by the master, so every read answer is a single-cycle pulse.
    assert property (@(posedge clk) disable iff (reset) rsp.valid |=> !rsp.valid)
        else $error("sram read answer lasted more than one cycle.");

endmodule

// ==== mod_io.sv ====
// switches and leds; switches must already be synchronous to clk and sw_w and led_w may not exceed 32.
`timescale 1ns/1ps

module mod_io #(
    parameter int led_w = 8,
    parameter int sw_w  = 8
) (
    input  logic                   clk,
    input  logic                   reset,
    input  bus_pkg::bus_req_t      req,
    input  logic                   misalign,
    input  mm_map_pkg::mm_module_e mod,
    input  logic [sw_w-1:0]        switches,  // board switch levels.
    output logic [led_w-1:0]       leds,      // board led drive.
    output bus_pkg::dev_rsp_t      rsp
);

    logic                          sw_sel;   // aligned access to the switches window.
    logic                          led_sel;  // aligned access to the leds window.
    logic [mm_map_pkg::data_w-1:0] rd_word;

    assign sw_sel  = (mod == mm_map_pkg::mod_switches) && !misalign;
    assign led_sel = (mod == mm_map_pkg::mod_leds) && !misalign;

    always_comb begin
        rd_word = '0;  // both sources are zero-extended.
        if (sw_sel) begin
            rd_word[sw_w-1:0] = switches;
        end else begin
            rd_word[led_w-1:0] = leds;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            leds      <= '0;
            rsp.valid <= 1'b0;
        end else begin
            if (led_sel && (req.op == bus_pkg::op_write)) begin
                leds <= req.wdata[led_w-1:0];  // upper write bits are dropped.
            end
            rsp.valid <= (sw_sel || led_sel) && (req.op == bus_pkg::op_read);
        end
        if ((sw_sel || led_sel) && (req.op == bus_pkg::op_read)) begin
            rsp.rdata <= rd_word;  // a write to the switches is silently ignored.
        end
    end

endmodule

// ==== mod_timer.sv ====
// free-running timer; it counts clk cycles and wraps at 32 bits, and a write replaces the count.
`timescale 1ns/1ps

module mod_timer (
    input  logic                   clk,
    input  logic                   reset,
    input  bus_pkg::bus_req_t      req,
    input  logic                   misalign,
    input  mm_map_pkg::mm_module_e mod,
    output bus_pkg::dev_rsp_t      rsp
);

    logic [mm_map_pkg::data_w-1:0] count;  // cycles since reset or the last load.
    logic                          sel;    // aligned access to the timer window.

    assign sel = (mod == mm_map_pkg::mod_timer) && !misalign;

    always_ff @(posedge clk) begin
        if (reset) begin
            count     <= '0;
            rsp.valid <= 1'b0;
        end else begin
            if (sel && (req.op == bus_pkg::op_write)) begin
                count <= req.wdata;  // the load replaces this cycle's increment.
            end else begin
                count <= count + 1'b1;
            end
            rsp.valid <= sel && (req.op == bus_pkg::op_read);
        end
        if (sel && (req.op == bus_pkg::op_read)) begin
            rsp.rdata <= count;  // value just before edge 2 of the read.
        end
    end

endmodule

// ==== bus_response_mux.sv ====
// output stage; it assumes a single request in flight, so one delay stage lines the request up with device data.
`timescale 1ns/1ps

module bus_response_mux (
    input  logic                   clk,
    input  logic                   reset,
    input  bus_pkg::bus_req_t      req,
    input  logic                   misalign,
    input  mm_map_pkg::mm_module_e mod,
    input  bus_pkg::dev_rsp_t      sram_rsp,
    input  bus_pkg::dev_rsp_t      io_rsp,
    input  bus_pkg::dev_rsp_t      timer_rsp,
    output bus_pkg::bus_rsp_t      rsp
);

    bus_pkg::bus_op_e       op_q;    // only the op of the request is needed here.
    mm_map_pkg::mm_module_e mod_q;
    logic                   mis_q;
    logic                   mapped;  // the window has a device behind it.

    always_ff @(posedge clk) begin
        if (reset) begin
            op_q  <= bus_pkg::op_idle;
            mod_q <= mm_map_pkg::mod_rom;
            mis_q <= 1'b0;
        end else begin
            op_q  <= req.op;  // same edge as the device registers.
            mod_q <= mod;
            mis_q <= misalign;
        end
    end

    assign mapped = mod_q inside {mm_map_pkg::mod_ram, mm_map_pkg::mod_switches,
                                  mm_map_pkg::mod_leds, mm_map_pkg::mod_timer};

    always_comb begin
        rsp.done  = (op_q != bus_pkg::op_idle);  // two cycles after the strobe.
        rsp.error = rsp.done && (mis_q || !mapped);
        rsp.rdata = ({mm_map_pkg::data_w{sram_rsp.valid}}  & sram_rsp.rdata) |
                    ({mm_map_pkg::data_w{io_rsp.valid}}    & io_rsp.rdata) |
                    ({mm_map_pkg::data_w{timer_rsp.valid}} & timer_rsp.rdata);
    end

    // the decoder gives each address one module, so two devices never answer together.
    assert property (@(posedge clk) disable iff (reset)
        $onehot0({sram_rsp.valid, io_rsp.valid, timer_rsp.valid}))
        else $error("more than one device answered in the same cycle.");

    // a clean read of a built window always found its device answering.
    assert property (@(posedge clk) disable iff (reset)
        (rsp.done && !rsp.error && (op_q == bus_pkg::op_read)) |->
        (sram_rsp.valid || io_rsp.valid || timer_rsp.valid))
        else $error("read finished without device data.");

endmodule

// ==== mm_bus_top.sv ====
// system bus top; one master, no back-pressure, and only sram, switches, leds and timer are built.
`timescale 1ns/1ps

module mm_bus_top #(
    parameter int sram_words = 1024,  // power of two.
    parameter int led_w      = 8,
    parameter int sw_w       = 8
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          rd,
    input  logic                          wr,
    input  logic [mm_map_pkg::addr_w-1:0] addr,
    input  logic [mm_map_pkg::data_w-1:0] wdata,
    input  logic [sw_w-1:0]               switches,
    output logic [led_w-1:0]              leds,
    output bus_pkg::bus_rsp_t             rsp
);

    bus_pkg::bus_req_t             req;        // registered request.
    logic                          misalign;
    mm_map_pkg::mm_module_e        mod;        // decoded window.
    logic [mm_map_pkg::addr_w-1:0] eff_addr;
    bus_pkg::dev_rsp_t             sram_rsp;
    bus_pkg::dev_rsp_t             io_rsp;
    bus_pkg::dev_rsp_t             timer_rsp;

    bus_request_reg u_request (
        .clk      (clk),
        .reset    (reset),
        .rd       (rd),
        .wr       (wr),
        .addr     (addr),
        .wdata    (wdata),
        .req      (req),
        .misalign (misalign)
    );

    mm u_mm (
        .addr     (req.addr),
        .mod      (mod),
        .eff_addr (eff_addr)
    );

    mod_sram #(.sram_words(sram_words)) u_sram (
        .clk      (clk),
        .reset    (reset),
        .req      (req),
        .misalign (misalign),
        .mod      (mod),
        .eff_addr (eff_addr),
        .rsp      (sram_rsp)
    );

    mod_io #(.led_w(led_w), .sw_w(sw_w)) u_io (
        .clk      (clk),
        .reset    (reset),
        .req      (req),
        .misalign (misalign),
        .mod      (mod),
        .switches (switches),
        .leds     (leds),
        .rsp      (io_rsp)
    );

    mod_timer u_timer (
        .clk      (clk),
        .reset    (reset),
        .req      (req),
        .misalign (misalign),
        .mod      (mod),
        .rsp      (timer_rsp)
    );

    bus_response_mux u_response (
        .clk       (clk),
        .reset     (reset),
        .req       (req),
        .misalign  (misalign),
        .mod       (mod),
        .sram_rsp  (sram_rsp),
        .io_rsp    (io_rsp),
        .timer_rsp (timer_rsp),
        .rsp       (rsp)
    );

endmodule

// ==== tb_mm_bus.sv ====
// testbench for mm_bus_top; it reads mm_bus_stimulus.txt from the working directory and stops at the first mismatch.
`timescale 1ns/1ps

module tb_mm_bus;

    localparam int sram_words = 256;  // word count behind the 0x10000000 window.
    localparam int led_w      = 8;
    localparam int sw_w       = 8;
    localparam logic [31:0] timer_addr = 32'hf060_0000;

    logic              clk;
    logic              reset;
    logic              rd;
    logic              wr;
    logic [31:0]       addr;
    logic [31:0]       wdata;
    logic [sw_w-1:0]   switches;
    logic [led_w-1:0]  leds;
    bus_pkg::bus_rsp_t rsp;

    string       ops[$];    // one letter per stimulus operation.
    logic [31:0] arg_a[$];  // first operand, address or value.
    logic [31:0] arg_b[$];  // second operand, data or expected value.
    int          cycle;     // rising edges since time zero.
    int          limit;     // timeout in cycles, zero until the file is read.

    mm_bus_top #(.sram_words(sram_words), .led_w(led_w), .sw_w(sw_w)) DUT (
        .clk      (clk),
        .reset    (reset),
        .rd       (rd),
        .wr       (wr),
        .addr     (addr),
        .wdata    (wdata),
        .switches (switches),
        .leds     (leds),
        .rsp      (rsp)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;  // 40 ns period.
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if ((limit > 0) && (cycle >= limit)) begin
            $display("timeout: the run did not finish within %0d cycles.", limit);
            $display(">>> FAIL");
            $fatal(1, "timeout");
        end
    end

    // compares one observed value with its expected value.
    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[FAIL] t=%0t %s actual=%h expected=%h", $time, name, actual, expected);
            $display(">>> FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    // issues one request just after an edge and waits for its done pulse.
    task automatic bus_access(input logic is_write, input logic [31:0] a,
                              input logic [31:0] d, output logic [31:0] rdata,
                              output logic err, output int strobe_at);
        int waited;
        waited    = 0;
        strobe_at = cycle;  // cycle of the edge that precedes the strobe.
        rd        = !is_write;
        wr        = is_write;
        addr      = a;
        wdata     = d;
        do begin
            @(posedge clk);
            #2;
            rd = 1'b0;  // strobes last one cycle.
            wr = 1'b0;
            waited++;
        end while (!rsp.done && (waited < 8));
        if (!rsp.done) begin
            $display("no done pulse came within %0d cycles of the request to %h.", waited, a);
            $display(">>> FAIL");
            $fatal(1, "missing done");
        end
        check_value("rsp.done latency", 32'(waited), 32'd2);  // fixed two-cycle latency.
        rdata = rsp.rdata;
        err   = rsp.error;
        repeat (1 + ($urandom % 4)) begin  // keeps requests at least three cycles apart.
            @(posedge clk);
            #2;
        end
    endtask

    // a write and a read to a window without a device must both end in a bus error.
    task automatic expect_error(input logic [31:0] a);
        logic [31:0] data;
        logic        err;
        int          at;
        bus_access(1'b1, a, 32'h5a5a_5a5a, data, err, at);
        check_value("rsp.error", {31'b0, err}, 32'd1);
        bus_access(1'b0, a, 32'd0, data, err, at);
        check_value("rsp.error", {31'b0, err}, 32'd1);
    endtask

    // loads the timer, then reads it twice with a random gap between the strobes.
    task automatic timer_test(input logic [31:0] x);
        logic [31:0] first;
        logic [31:0] second;
        logic [31:0] unused;
        logic        err;
        int          at_load;
        int          at_first;
        int          at_second;
        bus_access(1'b1, timer_addr, x, unused, err, at_load);
        check_value("rsp.error", {31'b0, err}, 32'd0);
        bus_access(1'b0, timer_addr, 32'd0, first, err, at_first);
        check_value("rsp.error", {31'b0, err}, 32'd0);
        bus_access(1'b0, timer_addr, 32'd0, second, err, at_second);
        check_value("rsp.error", {31'b0, err}, 32'd0);
        // the load lands on the edge where the count would otherwise have incremented.
        check_value("timer first read", first, x + 32'(at_first - at_load) - 32'd1);
        check_value("timer difference", second - first, 32'(at_second - at_first));
    endtask

    initial begin
        int          fd;
        int          r;
        int          nargs;
        int          at;
        string       tag;
        string       line;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] data;
        logic        err;
        void'($urandom(50));  // one seed for the whole run.
        reset    = 1'b1;
        rd       = 1'b0;
        wr       = 1'b0;
        addr     = 32'd0;
        wdata    = 32'd0;
        switches = '0;
        cycle    = 0;
        limit    = 0;
        fd = $fopen("mm_bus_stimulus.txt", "r");
        if (fd == 0) begin
            $display("the stimulus file mm_bus_stimulus.txt could not be opened.");
            $display(">>> FAIL");
            $fatal(1, "no stimulus");
        end
        r = $fscanf(fd, "%s", tag);
        while (r == 1) begin
            if (tag == "#") begin
                r = $fgets(line, fd);  // the rest of a comment line is dropped.
            end else begin
                nargs = (tag == "W" || tag == "R") ? 2 :
                        (tag == "E" || tag == "S" || tag == "L" || tag == "T") ? 1 : 0;
                b = 32'd0;
                if (nargs == 2) begin
                    r = $fscanf(fd, "%h %h", a, b);
                end else if (nargs == 1) begin
                    r = $fscanf(fd, "%h", a);
                end
                if ((nargs == 0) || (r != nargs)) begin
                    $display("the stimulus file holds a malformed line starting with %s.", tag);
                    $display(">>> FAIL");
                    $fatal(1, "bad stimulus");
                end
                ops.push_back(tag);
                arg_a.push_back(a);
                arg_b.push_back(b);
            end
            r = $fscanf(fd, "%s", tag);
        end
        $fclose(fd);
        limit = 20 * ops.size() + 100;
        repeat (5) begin  // reset spans five cycles and the bus must stay quiet.
            @(posedge clk);
            #2;
            check_value("rsp.done", {31'b0, rsp.done}, 32'd0);
            check_value("rsp.error", {31'b0, rsp.error}, 32'd0);
        end
        reset = 1'b0;
        for (int i = 0; i < ops.size(); i++) begin
            if (ops[i] == "W") begin
                bus_access(1'b1, arg_a[i], arg_b[i], data, err, at);
                check_value("rsp.error", {31'b0, err}, 32'd0);
            end else if (ops[i] == "R") begin
                bus_access(1'b0, arg_a[i], 32'd0, data, err, at);
                check_value("rsp.error", {31'b0, err}, 32'd0);
                check_value("rsp.rdata", data, arg_b[i]);
            end else if (ops[i] == "E") begin
                expect_error(arg_a[i]);
            end else if (ops[i] == "S") begin
                switches = arg_a[i][sw_w-1:0];  // held until the next S line.
            end else if (ops[i] == "L") begin
                check_value("leds", 32'(leds), arg_a[i]);
            end else begin
                timer_test(arg_a[i]);
            end
        end
        $display(">>> PASS");
        $finish;
    end

endmodule

// ==== mm_bus_stimulus.txt ====
# W addr data writes a word; R addr expected reads and compares; E addr expects errors on write and read
# S value sets the switches; L expected checks the led port; T value loads the timer and times two reads
W 10000000 12345678
W 10000004 cafef00d
W 100003fc 0badc0de
R 10000000 12345678
R 10000004 cafef00d
R 100003fc 0badc0de
R 10001000 12345678
R 10001ffc 0badc0de
W 10fffff8 a5a55a5a
R 100003f8 a5a55a5a
S 5c
R f0100000 0000005c
W f0200000 ffffff3c
L 3c
R f0200000 0000003c
T 00001000
T fffffffe
# windows without a device behind them
E f0000000
E f0300000
E f0400000
E f0500000
E f0700000
E f0a00000
E 00000000
E 20000000
E f0800000
# misaligned accesses must leave memory and leds unchanged
E 10000002
E f0200001
R 10000000 12345678
L 3c

// ==== build.f ====
mm_map_pkg.sv
bus_pkg.sv
bus_request_reg.sv
mm.sv
mod_sram.sv
mod_io.sv
mod_timer.sv
bus_response_mux.sv
mm_bus_top.sv
tb_mm_bus.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the testbench with verilator and runs it; the status follows the pass message.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f build.f --top-module tb_mm_bus -o sim_mm_bus \
    || { echo "verilator build failed"; exit 1; }
out=$(./obj_dir/sim_mm_bus)
echo "$out"
echo "$out" | grep -qx '>>> PASS' && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
